// ==== dotProduct.f ====
src/fpPkg.sv
src/treePkg.sv
src/fpMul.sv
src/fpAdd.sv
src/sumTree.sv
src/dotProduct.sv
verif/dotProduct_asserts.sv
verif/dotProductTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := dotProductTb
FILELIST  := dotProduct.f
BUILD_DIR := obj_dir
LOG       := sim.log
LINTFLAGS := --lint-only --timing --assert --top-module $(TOP)
SIMFLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/dotProductTb.sv ====
`default_nettype none

module dotProductTb;
    timeunit 1ns;
    timeprecision 100ps;

    import fpPkg::*;
    import treePkg::*;

    localparam int size        = 4;
    localparam int addersComb  = 1;
    localparam int latency     = 1 + treeLatency(size, addersComb);
    localparam int resetCycles = 5;
    localparam int idleCycles  = 4;
    localparam int numEntries  = 11;
    localparam int numPasses   = 2;
    localparam int numApplied  = numEntries * numPasses;
    localparam int cycleLimit  = numApplied * 2 + latency + resetCycles + 20;

    logic    clk;
    logic    arstN;
    logic    inValid;
    float32T vecA [size];
    float32T vecB [size];
    logic    outValid;
    float32T result;

    // Stimulus and expected sums in tree order (p0+p1)+(p2+p3)
    float32T tblA   [numEntries][size];
    float32T tblB   [numEntries][size];
    float32T tblExp [numEntries];

    float32T expQueue [$];
    int      checkedCount;
    int      passCount;
    int      failCount;
    int      cycleCount;

    dotProduct #(
        .size      (size),
        .addersComb(addersComb)
    ) dut (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (inValid),
        .vecA    (vecA),
        .vecB    (vecB),
        .outValid(outValid),
        .result  (result)
    );

    always #10 clk = ~clk;

    task automatic loadTable();
        // Exact integer sum 5+12+21+32
        tblA[0]   = '{32'h3F800000, 32'h40000000, 32'h40400000, 32'h40800000};
        tblB[0]   = '{32'h40A00000, 32'h40C00000, 32'h40E00000, 32'h41000000};
        tblExp[0] = 32'h428C0000;
        // Products cancel pairwise to +0
        tblA[1]   = '{32'h3F800000, 32'h3F800000, 32'h40000000, 32'h40000000};
        tblB[1]   = '{32'h40400000, 32'hC0400000, 32'h40A00000, 32'hC0A00000};
        tblExp[1] = 32'h00000000;
        // Zero, subnormal and -0 operands count as zero
        tblA[2]   = '{32'h00000000, 32'h00000001, 32'h40000000, 32'h80000000};
        tblB[2]   = '{32'h40A00000, 32'h40E00000, 32'h40400000, 32'h40800000};
        tblExp[2] = 32'h40C00000;
        // Only -0 terms keep the negative zero
        tblA[3]   = '{32'h80000000, 32'h80000000, 32'h80000000, 32'h80000000};
        tblB[3]   = '{32'h3F800000, 32'h3F800000, 32'h3F800000, 32'h3F800000};
        tblExp[3] = 32'h80000000;
        // 2^24 + 1 is a tie that stays on the even 2^24
        tblA[4]   = '{32'h4B800000, 32'h3F800000, 32'h00000000, 32'h00000000};
        tblB[4]   = '{32'h3F800000, 32'h3F800000, 32'h3F800000, 32'h3F800000};
        tblExp[4] = 32'h4B800000;
        // 2^24 + 3 is a tie that goes up to the even 2^24 + 4
        tblA[5]   = '{32'h4B800001, 32'h3F800000, 32'h00000000, 32'h00000000};
        tblB[5]   = '{32'h3F800000, 32'h3F800000, 32'h3F800000, 32'h3F800000};
        tblExp[5] = 32'h4B800002;
        // Two ties in tree order lose both ones
        tblA[6]   = '{32'h4B800000, 32'h3F800000, 32'h3F800000, 32'h00000000};
        tblB[6]   = '{32'h3F800000, 32'h3F800000, 32'h3F800000, 32'h3F800000};
        tblExp[6] = 32'h4B800000;
        // 2^100 squared overflows in the multiplier
        tblA[7]   = '{32'h71800000, 32'h00000000, 32'h00000000, 32'h00000000};
        tblB[7]   = '{32'h71800000, 32'h00000000, 32'h00000000, 32'h00000000};
        tblExp[7] = 32'h7F800000;
        // -2^127 twice overflows in the adder
        tblA[8]   = '{32'hFF000000, 32'hFF000000, 32'h00000000, 32'h00000000};
        tblB[8]   = '{32'h3F800000, 32'h3F800000, 32'h3F800000, 32'h3F800000};
        tblExp[8] = 32'hFF800000;
        // 2^-200 products flush to +0 and -0
        tblA[9]   = '{32'h0D800000, 32'h0D800000, 32'h00000000, 32'h00000000};
        tblB[9]   = '{32'h0D800000, 32'h8D800000, 32'h00000000, 32'h00000000};
        tblExp[9] = 32'h00000000;
        // Mixed signs and fractions give 3-10+4+4
        tblA[10]   = '{32'h3FC00000, 32'hC0200000, 32'h3E800000, 32'h41000000};
        tblB[10]   = '{32'h40000000, 32'h40800000, 32'h41800000, 32'h3F000000};
        tblExp[10] = 32'h3F800000;
    endtask

    task automatic driveEntry(int idx);
        @(posedge clk);
        #1;
        inValid = 1'b1;
        vecA    = tblA[idx];
        vecB    = tblB[idx];
        expQueue.push_back(tblExp[idx]);
    endtask

    task automatic driveIdle();
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    // Results are stable mid-cycle, so they are compared on the falling edge
    always @(negedge clk) begin : checkResult
        float32T expected;
        if (arstN === 1'b1 && outValid === 1'b1) begin
            assert (expQueue.size() != 0) else begin
                $display("outValid high at cycle %0d with no result pending", cycleCount);
                failCount++;
            end
            if (expQueue.size() != 0) begin
                expected = expQueue.pop_front();
                assert (result === expected) else begin
                    $display("mismatch result: got 0x%08h expected 0x%08h", result, expected);
                    failCount++;
                end
                if (result === expected) begin
                    passCount++;
                    $display("check %0d passed with result 0x%08h", checkedCount, result);
                end else begin
                    $display("check %0d failed", checkedCount);
                end
                checkedCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("run timed out after %0d cycles, %0d of %0d results checked",
                     cycleCount, checkedCount, numApplied);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : mainFlow
        int   gap;
        logic idleOk;
        clk          = 1'b0;
        arstN        = 1'b0;
        // Strobe held high through reset to show the valid pipeline ignores it
        inValid      = 1'b1;
        vecA         = '{default: '0};
        vecB         = '{default: '0};
        checkedCount = 0;
        passCount    = 0;
        failCount    = 0;
        cycleCount   = 0;
        idleOk       = 1'b1;
        void'($urandom(32'hd55d6d9d));
        loadTable();

        repeat (resetCycles) @(posedge clk);
        #1;
        arstN   = 1'b1;
        inValid = 1'b0;

        // No input yet, so no result may show up
        repeat (idleCycles) begin
            @(negedge clk);
            assert (outValid === 1'b0) else begin
                $display("outValid went high after reset with no input applied");
                idleOk = 1'b0;
            end
        end
        if (idleOk) begin
            passCount++;
            $display("idle check after reset passed");
        end else begin
            failCount++;
            $display("idle check after reset failed");
        end

        // First pass back to back, second pass with random idle gaps
        for (int pass = 0; pass < numPasses; pass++) begin
            for (int e = 0; e < numEntries; e++) begin
                driveEntry(e);
                if (pass > 0) begin
                    gap = $urandom % 2;
                    repeat (gap) driveIdle();
                end
            end
        end
        driveIdle();

        while (checkedCount < numApplied) begin
            @(posedge clk);
        end
        // A few more cycles to catch a stray outValid
        repeat (latency + 2) @(posedge clk);

        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/dotProduct_asserts.sv ====
`default_nettype none

module dotProduct_asserts #(
    parameter int size       = 4,
    parameter int addersComb = 1
) (
    input logic clk,
    input logic arstN,
    input logic inValid,
    input logic outValid
);
    timeunit 1ns;
    timeprecision 100ps;

    import treePkg::*;

    localparam int latency = 1 + treeLatency(size, addersComb);

    // Valid pipeline is cleared while reset is held
    resetLow : assert property (@(posedge clk) !arstN |-> !outValid)
        else $error("outValid high during reset");

    // Every accepted pair comes out after the fixed latency
    validLatency : assert property (@(posedge clk) disable iff (!arstN)
        inValid |-> ##latency outValid)
        else $error("outValid missing %0d cycles after inValid", latency);

    // No result without a pair accepted at the matching cycle
    noSpurious : assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> $past(inValid, latency))
        else $error("outValid high without a matching inValid");

endmodule

bind dotProduct dotProduct_asserts #(
    .size      (size),
    .addersComb(addersComb)
) uAsserts (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .outValid(outValid)
);

`default_nettype wire

// ==== src/dotProduct.sv ====
`default_nettype none

module dotProduct #(
    parameter int size       = 4,
    parameter int addersComb = 1
) (
    input  logic           clk,
    input  logic           arstN,
    input  logic           inValid,
    input  fpPkg::float32T vecA [size],
    input  fpPkg::float32T vecB [size],
    output logic           outValid,
    output fpPkg::float32T result
);
    import fpPkg::*;
    import treePkg::*;

    // Product register plus the registered tree layers
    localparam int latency = 1 + treeLatency(size, addersComb);

    float32T            prodComb [size];
    float32T            prodReg  [size];
    logic [latency-1:0] validPipe;

    for (genvar i = 0; i < size; i++) begin : gMul
        fpMul uMul (
            .a(vecA[i]),
            .b(vecB[i]),
            .p(prodComb[i])
        );
    end

    always_ff @(posedge clk) begin
        prodReg <= prodComb;
    end

    sumTree #(
        .size      (size),
        .addersComb(addersComb)
    ) uTree (
        .clk  (clk),
        .terms(prodReg),
        .sum  (result)
    );

    // Valid strobe follows the data through the same number of stages
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validPipe <= '0;
        end else begin
            validPipe <= (validPipe << 1) | latency'(inValid);
        end
    end

    assign outValid = validPipe[latency-1];

endmodule

`default_nettype wire

// ==== src/sumTree.sv ====
`default_nettype none

module sumTree #(
    parameter int size       = 2,
    parameter int addersComb = 1
) (
    input  logic           clk,
    input  fpPkg::float32T terms [size],
    output fpPkg::float32T sum
);
    import fpPkg::*;
    import treePkg::*;

    localparam int layers = $clog2(size);

    generate
        if (layers == 0) begin : gSingle
            // Nothing to add
            assign sum = terms[0];
        end else begin : gTree
            // Outputs of every layer, one after the other
            float32T results [getFirstReg(size, layers)];

            for (genvar i = 0; i < layers; i++) begin : gLayer
                localparam int addNum  = getAdderNum(size, i);
                localparam int regNum  = getRegsNum(size, i);
                localparam int inNum   = (i == 0) ? size : getRegsNum(size, i - 1);
                localparam int inBase  = (i == 0) ? 0 : getFirstReg(size, i - 1);
                localparam int outBase = getFirstReg(size, i);

                float32T src [inNum];

                // Layer 0 reads the terms, later layers the previous results
                for (genvar k = 0; k < inNum; k++) begin : gSrc
                    if (i == 0) begin : gTerm
                        assign src[k] = terms[k];
                    end else begin : gPrev
                        assign src[k] = results[inBase + k];
                    end
                end

                for (genvar j = 0; j < regNum; j++) begin : gNode
                    float32T node;
                    float32T stage;

                    if (j < addNum) begin : gAdd
                        fpAdd uAdd (
                            .a(src[2*j]),
                            .b(src[2*j + 1]),
                            .s(node)
                        );
                    end else begin : gOdd
                        // Odd value left over, carried to the next layer
                        assign node = src[2*j];
                    end

                    // Register after every addersComb-th layer
                    if (((i + 1) % addersComb) == 0) begin : gReg
                        always_ff @(posedge clk) begin
                            stage <= node;
                        end
                    end else begin : gComb
                        assign stage = node;
                    end

                    assign results[outBase + j] = stage;
                end
            end

            assign sum = results[getFirstReg(size, layers - 1)];
        end
    endgenerate

endmodule

`default_nettype wire

// ==== src/fpAdd.sv ====
`default_nettype none

module fpAdd (
    input  fpPkg::float32T a,
    input  fpPkg::float32T b,
    output fpPkg::float32T s
);
    import fpPkg::*;

    // Significand plus guard, round and sticky bits
    localparam int extW = 27;

    logic              zeroA;
    logic              zeroB;
    logic [30:0]       magA;
    logic [30:0]       magB;
    logic              swap;
    float32T           big;
    float32T           little;
    logic              zeroBig;
    logic              zeroSmall;
    expT               expBig;
    logic [7:0]        shiftAmt;
    logic [7:0]        shiftClamp;
    logic [extW-1:0]   extBig;
    logic [extW-1:0]   extSmall;
    logic [2*extW-1:0] wide;
    logic [extW-1:0]   aligned;
    logic              subtract;
    logic              zeroSign;
    logic [extW:0]     sumRaw;
    logic [4:0]        lz;
    logic [extW-1:0]   norm;
    logic signed [9:0] expNorm;
    logic signed [9:0] expFinal;
    logic              roundUp;
    logic [24:0]       sigRound;

    function automatic logic [4:0] countLz(logic [extW-1:0] v);
        logic [4:0] n;
        logic       found;
        n = '0;
        found = 1'b0;
        for (int i = extW - 1; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 5'd1;
                end
            end
        end
        return n;
    endfunction

    always_comb begin
        zeroA = isZeroOrSub(a);
        zeroB = isZeroOrSub(b);
        magA  = zeroA ? '0 : a[30:0];
        magB  = zeroB ? '0 : b[30:0];

        // Larger magnitude goes first
        swap      = magB > magA;
        big       = swap ? b : a;
        little    = swap ? a : b;
        zeroBig   = swap ? zeroB : zeroA;
        zeroSmall = swap ? zeroA : zeroB;
        expBig    = getExp(big);

        extBig   = zeroBig ? '0 : {1'b1, getMan(big), 3'b000};
        extSmall = zeroSmall ? '0 : {1'b1, getMan(little), 3'b000};

        // Bits shifted past the window end up in sticky
        shiftAmt   = expBig - getExp(little);
        shiftClamp = (shiftAmt > 8'(extW)) ? 8'(extW) : shiftAmt;
        wide       = {extSmall, {extW{1'b0}}} >> shiftClamp;
        aligned    = wide[2*extW-1:extW] | {{(extW-1){1'b0}}, |wide[extW-1:0]};

        subtract = getSign(a) ^ getSign(b);
        zeroSign = getSign(a) & getSign(b);
        if (subtract) begin
            sumRaw = {1'b0, extBig} - {1'b0, aligned};
        end else begin
            sumRaw = {1'b0, extBig} + {1'b0, aligned};
        end

        lz = countLz(sumRaw[extW-1:0]);
        if (sumRaw[extW]) begin
            // Carry out shifts one place right and keeps the lost bit as sticky
            norm    = {sumRaw[extW:2], sumRaw[1] | sumRaw[0]};
            expNorm = $signed({2'b00, expBig}) + 10'sd1;
        end else begin
            norm    = sumRaw[extW-1:0] << lz;
            expNorm = $signed({2'b00, expBig}) - $signed({5'b00000, lz});
        end

        // Nearest even on guard, round and sticky
        roundUp  = norm[2] & (norm[1] | norm[0] | norm[3]);
        sigRound = {1'b0, norm[extW-1:3]} + 25'(roundUp);
        if (sigRound[24]) begin
            expFinal = expNorm + 10'sd1;
        end else begin
            expFinal = expNorm;
        end

        if (sumRaw == '0 || expFinal <= 0) begin
            s = packFloat(zeroSign, '0, '0);
        end else if (expFinal >= 255) begin
            s = packFloat(getSign(big), '1, '0);
        end else begin
            s = packFloat(getSign(big), expT'(expFinal), sigRound[22:0]);
        end
    end

endmodule

`default_nettype wire

// ==== src/fpMul.sv ====
`default_nettype none

module fpMul (
    input  fpPkg::float32T a,
    input  fpPkg::float32T b,
    output fpPkg::float32T p
);
    import fpPkg::*;

    localparam int bias = 127;

    logic              sign;
    sigT               sigA;
    sigT               sigB;
    logic [47:0]       prod;
    logic signed [9:0] expSum;
    logic signed [9:0] expNorm;
    logic signed [9:0] expFinal;
    manT               manNorm;
    logic              guard;
    logic              roundBit;
    logic              sticky;
    logic              roundUp;
    logic [24:0]       sigRound;

    always_comb begin
        sign = getSign(a) ^ getSign(b);
        sigA = {1'b1, getMan(a)};
        sigB = {1'b1, getMan(b)};
        prod = 48'(sigA) * 48'(sigB);

        expSum = $signed({2'b00, getExp(a)}) + $signed({2'b00, getExp(b)})
               - 10'(bias);

        // Product of two values in [1,2) lies in [1,4)
        if (prod[47]) begin
            expNorm  = expSum + 10'sd1;
            manNorm  = prod[46:24];
            guard    = prod[23];
            roundBit = prod[22];
            sticky   = |prod[21:0];
        end else begin
            expNorm  = expSum;
            manNorm  = prod[45:23];
            guard    = prod[22];
            roundBit = prod[21];
            sticky   = |prod[20:0];
        end

        // Nearest even
        roundUp  = guard & (roundBit | sticky | manNorm[0]);
        sigRound = {2'b01, manNorm} + 25'(roundUp);

        // A carry out of the significand leaves an all-zero fraction
        if (sigRound[24]) begin
            expFinal = expNorm + 10'sd1;
        end else begin
            expFinal = expNorm;
        end

        if (isZeroOrSub(a) || isZeroOrSub(b) || expFinal <= 0) begin
            p = packFloat(sign, '0, '0);
        end else if (expFinal >= 255) begin
            p = packFloat(sign, '1, '0);
        end else begin
            p = packFloat(sign, expT'(expFinal), sigRound[22:0]);
        end
    end

endmodule

`default_nettype wire

// ==== src/treePkg.sv ====
`default_nettype none

package treePkg;

    // Adders in layer n, i.e. half of the values entering it, rounded down
    function automatic int getAdderNum(int size, int n);
        int temp;
        temp = size;
        for (int i = 0; i < n; i++) begin
            temp = (temp + 1) >> 1;
        end
        return temp >> 1;
    endfunction

    // Results leaving layer n, the entering count halved and rounded up
    function automatic int getRegsNum(int size, int n);
        int temp;
        temp = size;
        for (int i = 0; i <= n; i++) begin
            temp = (temp + 1) >> 1;
        end
        return temp;
    endfunction

    // Start of layer n inside the flat result array
    function automatic int getFirstReg(int size, int n);
        int temp;
        temp = 0;
        for (int i = 0; i < n; i++) begin
            temp += getRegsNum(size, i);
        end
        return temp;
    endfunction

    // Registered layers among the ceil(log2(size)) layers of the tree
    function automatic int treeLatency(int size, int addersComb);
        int layers;
        layers = $clog2(size);
        return layers / addersComb;
    endfunction

endpackage

`default_nettype wire

// ==== src/fpPkg.sv ====
`default_nettype none

package fpPkg;

    // Raw binary32 word and its fields
    typedef logic [31:0] float32T;
    typedef logic [7:0]  expT;
    typedef logic [22:0] manT;

    // Significand with the hidden bit in front
    typedef logic [23:0] sigT;

    function automatic logic getSign(float32T f);
        return f[31];
    endfunction

    function automatic expT getExp(float32T f);
        return f[30:23];
    endfunction

    function automatic manT getMan(float32T f);
        return f[22:0];
    endfunction

    function automatic float32T packFloat(logic sign, expT exp, manT man);
        return {sign, exp, man};
    endfunction

    // Subnormals are read as zero, so only the exponent field matters
    function automatic logic isZeroOrSub(float32T f);
        return f[30:23] == '0;
    endfunction

endpackage

`default_nettype wire
